// ==== ethRt_settings.svh ====
// Frame constants for the real-time Ethernet byte interface.
// Included by the RTL blocks and the testbench that need Ethernet
// framing or CRC values.

`ifndef ETHRT_SETTINGS_SVH
`define ETHRT_SETTINGS_SVH

// ----------------------------------------
// Preamble and delimiter
// ----------------------------------------
`define ETH_PREAMBLE_LEN   7              // Preamble bytes before the SFD
`define ETH_PREAMBLE_BYTE  8'h55          // Preamble pattern
`define ETH_SFD            8'hd5          // Start-of-frame delimiter

// ----------------------------------------
// Frame size and FCS
// ----------------------------------------
`define ETH_MIN_PAYLOAD    60             // Bytes before the FCS, pad up to this
`define ETH_CRC_INIT       32'hffff_ffff  // CRC register preset

// Register value after data and FCS have both been folded in
`define ETH_CRC_RESIDUE    32'hdebb_20e3

`endif

// ==== ethRtPkg.sv ====
// Shared types for the real-time Ethernet byte interface.
// Used by the RTL blocks and the testbench through scoped names.
// Holds the GMII byte lane, the received word and the transmit request.

`default_nettype none

package ethRtPkg;

    // ----------------------------------------
    // GMII byte lane, used for both directions
    // ----------------------------------------
    typedef struct packed {
        logic       en;    // Byte valid
        logic [7:0] data;  // Byte value
        logic       err;   // Error marker, always 0 on transmit
    } gmiiByteT;

    // ----------------------------------------
    // Word toward the protocol engine
    // ----------------------------------------
    typedef struct packed {
        logic        valid;  // One-cycle strobe
        logic        last;   // Final word of the frame
        logic [15:0] data;   // First byte in the upper half
    } rxWordT;

    // ----------------------------------------
    // Frame-level transmit request
    // ----------------------------------------
    // Four-phase with txAck. byteCount stays stable while req is high
    typedef struct packed {
        logic        req;        // Request level
        logic [15:0] byteCount;  // Payload bytes, at least 1
    } txReqT;

endpackage

`default_nettype wire

// ==== ethCrc32.sv ====
// Byte-wide reflected CRC-32 register for the Ethernet FCS.
// crcInit presets the register, crcAdvance folds in crcByte LSB first.
// The new value shows on crcValue one cycle after crcAdvance.

`timescale 1ns/1ns
`default_nettype none

`include "ethRt_settings.svh"

module ethCrc32 (
    input  wire        TxClk,
    input  wire        rstN,
    input  wire        crcInit,     // Preset to all ones
    input  wire        crcAdvance,  // Fold crcByte in
    input  wire  [7:0] crcByte,
    output logic [31:0] crcValue    // Raw register, not inverted
);

    localparam logic [31:0] CRC_POLY = 32'hedb8_8320;  // Reflected 802.3 polynomial

    // One byte through the shift register, LSB first
    function automatic logic [31:0] crcNext(input logic [31:0] crcIn,
                                            input logic [7:0]  dataIn);
        logic [31:0] c;
        c = crcIn ^ {24'd0, dataIn};
        for (int i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge TxClk) begin
        if (!rstN) begin
            crcValue <= `ETH_CRC_INIT;
        end
        else if (crcInit) begin
            crcValue <= `ETH_CRC_INIT;             // Init wins over advance
        end
        else if (crcAdvance) begin
            crcValue <= crcNext(crcValue, crcByte);
        end
    end

endmodule

`default_nettype wire

// ==== ethRxDeframer.sv ====
// Receive side of the GMII byte interface.
// Drops the preamble, packs bytes after the SFD into 16-bit words for the
// engine (first byte high), pads an odd last byte and marks the last word.
// A frame that arrives while rxBusy is low is flushed and flagged.

`timescale 1ns/1ns
`default_nettype none

`include "ethRt_settings.svh"

module ethRxDeframer (
    input  wire                 TxClk,
    input  wire                 rstN,
    input  wire ethRtPkg::gmiiByteT gmiiRx,
    input  wire                 rxBusy,         // Engine accepts a frame
    input  wire                 clearErrors,
    output logic                rxRequest,      // SFD to end of frame
    output ethRtPkg::rxWordT    rxWord,
    output logic                internalError   // Sticky not-ready flag
);

    typedef enum logic [1:0] {
        stIdle,   // Hunting for the SFD
        stFrame,  // Packing payload bytes
        stPad,    // Emitting the zero-padded odd word
        stFlush   // Dropping a frame the engine did not take
    } rxStateT;

    rxStateT     rxState;
    logic        oddPhase;    // Next byte completes a word
    logic [7:0]  upperByte;   // Even byte waiting for its partner
    logic [15:0] heldWord;    // Last completed word, held back one pair
    logic        haveHeld;    // heldWord is valid

    // ----------------------------------------
    // Frame FSM and word packing
    // ----------------------------------------
    always_ff @(posedge TxClk) begin
        if (!rstN) begin
            rxState       <= stIdle;
            rxRequest     <= 1'b0;
            rxWord.valid  <= 1'b0;
            rxWord.last   <= 1'b0;
            internalError <= 1'b0;
            oddPhase      <= 1'b0;
            haveHeld      <= 1'b0;
        end
        else begin
            rxWord.valid <= 1'b0;              // Strobes by default
            rxWord.last  <= 1'b0;

            if (clearErrors)
                internalError <= 1'b0;         // Set below takes priority

            case (rxState)
                stIdle: begin
                    // Preamble bytes pass by unchecked
                    if (gmiiRx.en && gmiiRx.data == `ETH_SFD) begin
                        rxRequest <= 1'b1;
                        oddPhase  <= 1'b0;
                        haveHeld  <= 1'b0;
                        if (rxBusy) begin
                            rxState <= stFrame;
                        end
                        else begin
                            internalError <= 1'b1;   // Engine not ready
                            rxState       <= stFlush;
                        end
                    end
                end

                stFrame: begin
                    if (gmiiRx.en) begin
                        oddPhase <= ~oddPhase;
                        if (!oddPhase) begin
                            upperByte <= gmiiRx.data;            // Even byte, high half
                        end
                        else begin
                            // Release the previous pair, hold the new one
                            rxWord.valid <= haveHeld;
                            rxWord.data  <= heldWord;
                            heldWord     <= {upperByte, gmiiRx.data};
                            haveHeld     <= 1'b1;
                        end
                    end
                    else begin
                        // End of frame, enable low with rxRequest high
                        rxRequest    <= 1'b0;
                        rxWord.valid <= haveHeld;
                        rxWord.last  <= haveHeld && !oddPhase;  // Even count ends here
                        rxWord.data  <= heldWord;
                        haveHeld     <= 1'b0;
                        rxState      <= oddPhase ? stPad : stIdle;
                    end
                end

                stPad: begin
                    rxWord.valid <= 1'b1;
                    rxWord.last  <= 1'b1;
                    rxWord.data  <= {upperByte, 8'h00};  // Odd byte, zero low half
                    rxState      <= stIdle;
                end

                stFlush: begin
                    if (!gmiiRx.en) begin
                        rxRequest <= 1'b0;
                        rxState   <= stIdle;
                    end
                end

                default: rxState <= stIdle;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // The pad word may trail rxRequest by two cycles, never more
    assert property (@(posedge TxClk) disable iff (!rstN)
        (!rxRequest && !$past(rxRequest) && !$past(rxRequest, 2))
            |-> !$rose(rxWord.valid))
        else $error("rxWord.valid rose outside a frame");

endmodule

`default_nettype wire

// ==== ethTxFramer.sv ====
// Transmit side of the GMII byte interface.
// On a four-phase request it sends the preamble and SFD, fetches payload
// words from the engine (low byte first), pads to the minimum size and
// appends the FCS from the CRC block. txAck rises once the frame is out.

`timescale 1ns/1ns
`default_nettype none

`include "ethRt_settings.svh"

module ethTxFramer (
    input  wire                 TxClk,
    input  wire                 rstN,
    input  wire ethRtPkg::txReqT txReq,
    output logic                txAck,
    output logic                txWordReq,   // Word wanted on the next cycle
    input  wire          [15:0] txWord,
    output logic                crcInit,
    output logic                crcAdvance,
    output logic          [7:0] crcByte,
    input  wire          [31:0] crcValue,
    output ethRtPkg::gmiiByteT  gmiiTx
);

    localparam logic [2:0]  PRE_LEN = 3'(`ETH_PREAMBLE_LEN);
    localparam logic [15:0] MIN_LEN = 16'(`ETH_MIN_PAYLOAD);

    typedef enum logic [2:0] {
        stIdle,
        stPreamble,  // Preamble bytes, then the SFD
        stSend,      // Payload bytes from the engine
        stPadding,   // Zero bytes up to MIN_LEN
        stCrc,       // Four FCS bytes
        stDone       // Ack handshake
    } txStateT;

    txStateT     txState;
    logic [2:0]  preCnt;       // Preamble bytes already loaded
    logic [15:0] byteCnt;      // Data and pad bytes already loaded
    logic [1:0]  fcsCnt;       // FCS byte index
    logic [15:0] byteCountQ;   // Latched payload length
    logic [7:0]  wordHi;       // High byte of the current word
    logic [7:0]  txByte;       // Next data or pad byte
    logic        moreWords;    // Another word follows the current one

    // ----------------------------------------
    // Next data byte and CRC feed
    // ----------------------------------------
    always_comb begin
        txByte = 8'h00;                                      // Pad value
        if (txState == stSend)
            txByte = byteCnt[0] ? wordHi : txWord[7:0];     // Low byte first
    end

    assign moreWords  = ({1'b0, byteCnt} + 17'd2) < {1'b0, byteCountQ};
    assign crcInit    = (txState == stPreamble);            // Held through the preamble
    assign crcAdvance = (txState == stSend) || (txState == stPadding);
    assign crcByte    = txByte;                             // Same byte as gmiiTx gets

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge TxClk) begin
        if (!rstN) begin
            txState   <= stIdle;
            gmiiTx    <= '0;
            txAck     <= 1'b0;
            txWordReq <= 1'b0;
            preCnt    <= 3'd0;
            byteCnt   <= 16'd0;
            fcsCnt    <= 2'd0;
        end
        else begin
            txWordReq <= 1'b0;

            case (txState)
                stIdle: begin
                    gmiiTx.en <= 1'b0;
                    if (txReq.req && !txAck) begin
                        gmiiTx.en   <= 1'b1;
                        gmiiTx.data <= `ETH_PREAMBLE_BYTE;   // First preamble byte
                        preCnt      <= 3'd1;
                        byteCountQ  <= txReq.byteCount;
                        txState     <= stPreamble;
                    end
                end

                stPreamble: begin
                    if (preCnt == PRE_LEN) begin
                        gmiiTx.data <= `ETH_SFD;
                        byteCnt     <= 16'd0;
                        txState     <= stSend;
                    end
                    else begin
                        gmiiTx.data <= `ETH_PREAMBLE_BYTE;
                        preCnt      <= preCnt + 3'd1;
                        txWordReq   <= (preCnt == PRE_LEN - 3'd1);  // With the last one
                    end
                end

                stSend: begin
                    gmiiTx.data <= txByte;
                    byteCnt     <= byteCnt + 16'd1;
                    if (!byteCnt[0]) begin
                        wordHi    <= txWord[15:8];    // Word is valid this cycle
                        txWordReq <= moreWords;       // Fetch ahead for the next pair
                    end
                    if (byteCnt == byteCountQ - 16'd1) begin
                        fcsCnt  <= 2'd0;
                        txState <= (byteCountQ < MIN_LEN) ? stPadding : stCrc;
                    end
                end

                stPadding: begin
                    gmiiTx.data <= txByte;
                    byteCnt     <= byteCnt + 16'd1;
                    if (byteCnt == MIN_LEN - 16'd1)
                        txState <= stCrc;
                end

                stCrc: begin
                    // Final register goes out inverted and LSB first
                    gmiiTx.data <= ~crcValue[{fcsCnt, 3'b000} +: 8];
                    fcsCnt      <= fcsCnt + 2'd1;
                    if (fcsCnt == 2'd3)
                        txState <= stDone;
                end

                stDone: begin
                    gmiiTx.en <= 1'b0;
                    txAck     <= 1'b1;
                    if (txAck && !txReq.req) begin
                        txAck   <= 1'b0;               // Requester let go
                        txState <= stIdle;
                    end
                end

                default: txState <= stIdle;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge TxClk) disable iff (!rstN)
        $rose(txAck) |-> $past(txReq.req))
        else $error("txAck rose without a request");

    assert property (@(posedge TxClk) disable iff (!rstN)
        (txState == stIdle && txReq.req && !txAck) |-> (txReq.byteCount != 16'd0))
        else $error("Frame started with zero byteCount");

    // Enable may only fall once the last FCS byte is out
    assert property (@(posedge TxClk) disable iff (!rstN)
        $fell(gmiiTx.en) |-> $past(txState == stDone))
        else $error("gmiiTx enable dropped inside a frame");

endmodule

`default_nettype wire

// ==== ethRtInterface.sv ====
// Top level of the real-time Ethernet byte interface.
// Sits between a GMII switch port and the word-oriented protocol engine.
// Wires the receive deframer, the transmit framer and the FCS CRC block.
// Adds no registers, latencies are those of the blocks.

`timescale 1ns/1ns
`default_nettype none

module ethRtInterface (
    input  wire                  TxClk,
    input  wire                  rstN,

    // Receive side
    input  wire ethRtPkg::gmiiByteT gmiiRx,     // From the switch
    input  wire                  rxBusy,
    input  wire                  clearErrors,
    output wire                  rxRequest,
    output ethRtPkg::rxWordT     rxWord,        // To the engine
    output wire                  internalError,

    // Transmit side
    input  wire ethRtPkg::txReqT txReq,
    output wire                  txAck,
    output wire                  txWordReq,
    input  wire           [15:0] txWord,
    output ethRtPkg::gmiiByteT   gmiiTx         // To the switch
);

    // Framer to CRC block
    wire        crcInit;
    wire        crcAdvance;
    wire  [7:0] crcByte;
    wire [31:0] crcValue;

    // ----------------------------------------
    // Receive path
    // ----------------------------------------
    ethRxDeframer rxDeframer (
        .TxClk         (TxClk),
        .rstN          (rstN),
        .gmiiRx        (gmiiRx),
        .rxBusy        (rxBusy),
        .clearErrors   (clearErrors),
        .rxRequest     (rxRequest),
        .rxWord        (rxWord),
        .internalError (internalError)
    );

    // ----------------------------------------
    // Transmit path
    // ----------------------------------------
    ethTxFramer txFramer (
        .TxClk      (TxClk),
        .rstN       (rstN),
        .txReq      (txReq),
        .txAck      (txAck),
        .txWordReq  (txWordReq),
        .txWord     (txWord),
        .crcInit    (crcInit),
        .crcAdvance (crcAdvance),
        .crcByte    (crcByte),
        .crcValue   (crcValue),
        .gmiiTx     (gmiiTx)
    );

    ethCrc32 fcsCrc (
        .TxClk      (TxClk),
        .rstN       (rstN),
        .crcInit    (crcInit),
        .crcAdvance (crcAdvance),
        .crcByte    (crcByte),
        .crcValue   (crcValue)
    );

endmodule

`default_nettype wire

// ==== ethRtInterface_tb.sv ====
// Testbench for the real-time Ethernet byte interface.
// Loops gmiiTx back into gmiiRx and runs a table of frames through the
// four-phase transmit request. The GMII bytes, the FCS and the received
// words are compared with values built here from the framing rules.

`timescale 1ns/1ns
`default_nettype none

`include "ethRt_settings.svh"

module ethRtInterface_tb;

    localparam int NUM_TESTS = 7;
    localparam int TIMEOUT   = 500;                     // Cycles allowed per wait
    localparam int HDR_LEN   = `ETH_PREAMBLE_LEN + 1;   // Preamble plus SFD

    typedef struct packed {
        logic [15:0] byteCount;
        logic        rxBusy;    // Engine ready for the looped-back frame
        logic        expErr;    // internalError after the frame
    } caseT;

    string testNames [NUM_TESTS] = '{"len1", "len2", "len59", "notReady",
                                     "len60", "len61", "len100"};
    caseT  cases [NUM_TESTS] = '{
        '{16'd1,   1'b1, 1'b0},
        '{16'd2,   1'b1, 1'b0},
        '{16'd59,  1'b1, 1'b0},
        '{16'd40,  1'b0, 1'b1},   // Flushed, then cleared
        '{16'd60,  1'b1, 1'b0},
        '{16'd61,  1'b1, 1'b0},   // Odd length above the minimum
        '{16'd100, 1'b1, 1'b0}
    };

    logic               TxClk;
    logic               rstN;
    ethRtPkg::gmiiByteT gmiiRx;
    ethRtPkg::gmiiByteT gmiiTx;
    logic               rxBusy;
    logic               clearErrors;
    logic               rxRequest;
    ethRtPkg::rxWordT   rxWord;
    logic               internalError;
    ethRtPkg::txReqT    txReq;
    logic               txAck;
    logic               txWordReq;
    logic [15:0]        txWord;

    string       testName;
    logic [31:0] lcgState = 32'hacc4_862c;
    logic [15:0] words [64];       // Engine-side payload words
    int          numWords;
    int          wordIdx;          // Next word to hand out
    logic        wordPending;      // Strobe seen in the last cycle
    logic [7:0]  expBytes [256];   // Expected gmiiTx stream
    logic [7:0]  txSeen [$];
    logic [15:0] rxSeen [$];
    logic        lastSeen [$];
    logic        txEnFell;         // Enable already dropped in this frame

    ethRtInterface u_dut (
        .TxClk         (TxClk),
        .rstN          (rstN),
        .gmiiRx        (gmiiRx),
        .rxBusy        (rxBusy),
        .clearErrors   (clearErrors),
        .rxRequest     (rxRequest),
        .rxWord        (rxWord),
        .internalError (internalError),
        .txReq         (txReq),
        .txAck         (txAck),
        .txWordReq     (txWordReq),
        .txWord        (txWord),
        .gmiiTx        (gmiiTx)
    );

    initial TxClk = 1'b0;
    always #2 TxClk = ~TxClk;   // 4 ns period

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bit-serial reflected CRC-32 over expBytes that returns the raw register
    function automatic logic [31:0] refCrc(input int first, input int count);
        logic [31:0] crc;
        logic        fb;
        crc = `ETH_CRC_INIT;
        for (int i = first; i < first + count; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ expBytes[i][b];   // LSB first
                crc = {1'b0, crc[31:1]};
                if (fb)
                    crc = crc ^ 32'hedb8_8320;
            end
        end
        return crc;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
            failRun($sformatf("Mismatch in %s: %s expected 0x%0h actual 0x%0h",
                              testName, what, expected, actual));
    endtask

    // ----------------------------------------
    // Clock step that samples and then drives at edge + 1 ns
    // ----------------------------------------
    task automatic tick();
        @(posedge TxClk);
        #1;
        checkEq("gmiiTx.err", 0, 32'(gmiiTx.err));
        if (gmiiTx.en) begin
            if (txEnFell)
                failRun($sformatf("In %s gmiiTx enable rose again inside the frame",
                                  testName));
            txSeen.push_back(gmiiTx.data);
        end
        else if (txSeen.size() > 0) begin
            txEnFell = 1'b1;
        end
        if (rxWord.valid) begin
            rxSeen.push_back(rxWord.data);
            lastSeen.push_back(rxWord.last);
        end
        gmiiRx = gmiiTx;                       // Loopback
        if (wordPending) begin
            // Word due one cycle after the strobe
            if (wordIdx >= numWords)
                failRun($sformatf("In %s txWordReq came after the last payload word",
                                  testName));
            txWord  = words[wordIdx];
            wordIdx = wordIdx + 1;
        end
        wordPending = txWordReq;
    endtask

    task automatic stepWait(input string what, inout int cnt);
        tick();
        cnt = cnt + 1;
        if (cnt > TIMEOUT)
            failRun($sformatf("Timeout in %s: %s never arrived", testName, what));
    endtask

    task automatic runFrame(input int t);
        int          n;
        int          padded;
        int          rxLen;
        int          cnt;
        logic [31:0] fcs;
        logic [15:0] expWord;
        testName = testNames[t];
        n        = 32'(cases[t].byteCount);
        padded   = (n < `ETH_MIN_PAYLOAD) ? `ETH_MIN_PAYLOAD : n;
        numWords = (n + 1) / 2;
        for (int w = 0; w < numWords; w++) begin
            lcgState = lcgNext(lcgState);
            words[w] = lcgState[31:16];        // Upper LCG bits are the better ones
        end

        // Expected stream of preamble, SFD, payload low byte first, zero pad and FCS
        for (int i = 0; i < HDR_LEN; i++)
            expBytes[i] = (i < `ETH_PREAMBLE_LEN) ? `ETH_PREAMBLE_BYTE : `ETH_SFD;
        for (int i = 0; i < padded; i++)
            expBytes[HDR_LEN + i] = (i >= n) ? 8'h00 :
                                    (i[0] ? words[i / 2][15:8] : words[i / 2][7:0]);
        fcs = ~refCrc(HDR_LEN, padded);
        for (int k = 0; k < 4; k++)
            expBytes[HDR_LEN + padded + k] = fcs[8 * k +: 8];
        checkEq("reference residue", `ETH_CRC_RESIDUE, refCrc(HDR_LEN, padded + 4));

        txSeen.delete();
        rxSeen.delete();
        lastSeen.delete();
        txEnFell    = 1'b0;
        wordIdx     = 0;
        wordPending = 1'b0;
        rxBusy          = cases[t].rxBusy;
        txReq.byteCount = cases[t].byteCount;
        txReq.req       = 1'b1;
        tick();
        checkEq("gmiiTx.en one cycle after req", 1, 32'(gmiiTx.en));

        // Four-phase handshake
        cnt = 0;
        while (!txAck)
            stepWait("txAck rise", cnt);
        checkEq("gmiiTx bytes at txAck rise", HDR_LEN + padded + 4, txSeen.size());
        tick();                                // Req stays high one more cycle
        checkEq("txAck while req high", 1, 32'(txAck));
        txReq.req = 1'b0;
        cnt = 0;
        while (txAck)
            stepWait("txAck fall", cnt);

        if (cases[t].rxBusy) begin
            cnt = 0;
            while (lastSeen.size() == 0 || !lastSeen[$])
                stepWait("rxWord with last", cnt);
        end
        else begin
            cnt = 0;
            while (rxRequest)
                stepWait("rxRequest fall", cnt);
        end

        checkEq("gmiiTx byte count", HDR_LEN + padded + 4, txSeen.size());
        for (int i = 0; i < HDR_LEN + padded + 4; i++)
            checkEq($sformatf("gmiiTx byte %0d", i), 32'(expBytes[i]), 32'(txSeen[i]));
        checkEq("txWordReq count", numWords, wordIdx);

        if (cases[t].rxBusy) begin
            rxLen = padded + 4;
            checkEq("rxWord count", (rxLen + 1) / 2, rxSeen.size());
            for (int k = 0; k < (rxLen + 1) / 2; k++) begin
                expWord = {expBytes[HDR_LEN + 2 * k],
                           (2 * k + 1 < rxLen) ? expBytes[HDR_LEN + 2 * k + 1] : 8'h00};
                checkEq($sformatf("rxWord %0d", k), 32'(expWord), 32'(rxSeen[k]));
                checkEq($sformatf("rxWord %0d last", k),
                        32'(k == (rxLen + 1) / 2 - 1), 32'(lastSeen[k]));
            end
            checkEq("rxRequest after frame", 0, 32'(rxRequest));
        end
        else begin
            checkEq("rxWord strobes in flush", 0, rxSeen.size());
        end

        checkEq("internalError", 32'(cases[t].expErr), 32'(internalError));
        if (cases[t].expErr) begin
            clearErrors = 1'b1;
            tick();
            clearErrors = 1'b0;
            checkEq("internalError after clearErrors", 0, 32'(internalError));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rstN        = 1'b0;
        gmiiRx      = '0;
        rxBusy      = 1'b0;
        clearErrors = 1'b0;
        txReq       = '0;
        txWord      = '0;
        wordPending = 1'b0;
        wordIdx     = 0;
        numWords    = 0;
        txEnFell    = 1'b0;
        testName    = "reset";
        repeat (5) @(posedge TxClk);
        #1;
        rstN = 1'b1;

        checkEq("gmiiTx.en", 0, 32'(gmiiTx.en));
        checkEq("txAck", 0, 32'(txAck));
        checkEq("txWordReq", 0, 32'(txWordReq));
        checkEq("rxRequest", 0, 32'(rxRequest));
        checkEq("rxWord.valid", 0, 32'(rxWord.valid));
        checkEq("internalError", 0, 32'(internalError));

        for (int t = 0; t < NUM_TESTS; t++)
            runFrame(t);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ethRtInterface.f ====
+incdir+.
ethRtPkg.sv
ethCrc32.sv
ethRxDeframer.sv
ethTxFramer.sv
ethRtInterface.sv
ethRtInterface_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f ethRtInterface.f --top-module ethRtInterface_tb \
    && ./obj_dir/VethRtInterface_tb > "$LOG" 2>&1 \
    || { echo "Build or simulation failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "STATUS: PASS" "$LOG" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
